/* source/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path and address width
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32

// data memory depth in words
`define RV_DMEM_WORDS 64

// pc value loaded by reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* source/rvIsaPkg.sv */
package rvIsaPkg;

    // major opcodes of the supported subset, instr[6:0]
    typedef enum logic [6:0]
    {
        OP_REG    = 7'b0110011,  // register-register alu ops
        OP_IMM    = 7'b0010011,  // register-immediate alu ops
        OP_LOAD   = 7'b0000011,  // loads
        OP_STORE  = 7'b0100011,  // stores
        OP_BRANCH = 7'b1100011,  // conditional branches
        OP_JAL    = 7'b1101111,  // jump and link
        OP_LUI    = 7'b0110111   // load upper immediate
    } opcodeT;

    // funct3 of OP_REG and OP_IMM
    typedef enum logic [2:0]
    {
        ADD_SUB = 3'b000,  // add, addi, sub when bit 30 set on OP_REG
        SLT     = 3'b010,  // signed set less than
        XOR     = 3'b100,  // bitwise xor
        OR      = 3'b110,  // bitwise or
        AND     = 3'b111   // bitwise and
    } aluFunct3T;

    // funct3 of OP_BRANCH
    typedef enum logic [2:0]
    {
        BEQ = 3'b000,  // taken when equal
        BNE = 3'b001   // taken when not equal
    } branchFunct3T;

    // funct3 of OP_LOAD and OP_STORE
    typedef enum logic [2:0]
    {
        WORD = 3'b010  // full 32-bit access only
    } memFunct3T;

endpackage

/* source/rvCtrlPkg.sv */
package rvCtrlPkg;

    // alu operation select, zero encoding is the idle default
    typedef enum logic [2:0]
    {
        ALU_ADD   = 3'b000,  // a + b
        ALU_SUB   = 3'b001,  // a - b, also branch compare
        ALU_AND   = 3'b010,  // a & b
        ALU_OR    = 3'b011,  // a | b
        ALU_XOR   = 3'b100,  // a ^ b
        ALU_SLT   = 3'b101,  // signed a < b
        ALU_PASSB = 3'b110   // b straight through for lui
    } aluOpT;

    // immediate format, I is the zero default
    typedef enum logic [2:0]
    {
        IMM_I = 3'b000,  // 12-bit signed, alu imm and loads
        IMM_S = 3'b001,  // split store offset
        IMM_B = 3'b010,  // branch offset, bit 0 implied
        IMM_U = 3'b011,  // upper 20 bits
        IMM_J = 3'b100   // jal offset, bit 0 implied
    } immSrcT;

    // write-back value select
    typedef enum logic [1:0]
    {
        RES_ALU = 2'b00,  // alu result
        RES_MEM = 2'b01,  // data memory read
        RES_PC4 = 2'b10   // link address for jal
    } resultSrcT;

endpackage

/* source/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
(
    input  rvIsaPkg::opcodeT      op,         // instr[6:0]
    input  logic [2:0]            funct3,     // instr[14:12]
    input  logic                  funct7,     // instr[30]
    input  logic                  zero,       // alu result is zero
    output logic                  regWrite,   // rd write request
    output rvCtrlPkg::aluOpT      aluCtrl,    // alu operation
    output logic                  aluSrc,     // operand b from immediate
    output rvCtrlPkg::immSrcT     immSrc,     // immediate format
    output logic                  pcSrc,      // take pc + imm
    output logic                  memWrite,   // data memory store
    output rvCtrlPkg::resultSrcT  resultSrc   // write-back select
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    aluOpT f3Op;     // alu op implied by funct3
    logic  f3Legal;  // funct3 is one we execute
    logic  isBeq;    // decoded beq
    logic  isBne;    // decoded bne
    logic  isJal;    // decoded jal

    // funct3 to alu op, shared by OP_REG and OP_IMM
    always_comb
    begin
        f3Op    = ALU_ADD;
        f3Legal = 1'b1;
        case (funct3)
            ADD_SUB: f3Op = ALU_ADD;
            SLT:     f3Op = ALU_SLT;
            XOR:     f3Op = ALU_XOR;
            OR:      f3Op = ALU_OR;
            AND:     f3Op = ALU_AND;
            default: f3Legal = 1'b0;  // shifts and sltu not supported
        endcase
    end

    // main decode, everything starts inactive
    always_comb
    begin
        regWrite  = 1'b0;
        aluCtrl   = ALU_ADD;
        aluSrc    = 1'b0;
        immSrc    = IMM_I;
        memWrite  = 1'b0;
        resultSrc = RES_ALU;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJal     = 1'b0;
        case (op)
            OP_REG:
            begin
                if (f3Legal)
                begin
                    regWrite = 1'b1;
                    // bit 30 picks sub only for the add slot
                    aluCtrl  = (funct3 == ADD_SUB && funct7) ? ALU_SUB : f3Op;
                end
            end
            OP_IMM:
            begin
                if (f3Legal)
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;  // I-type immediate as operand b
                    aluCtrl  = f3Op;  // bit 30 is part of the immediate here
                end
            end
            OP_LOAD:
            begin
                case (funct3)
                    WORD:
                    begin
                        regWrite  = 1'b1;
                        aluSrc    = 1'b1;     // rs1 + offset
                        resultSrc = RES_MEM;  // write back the loaded word
                    end
                    default: ;  // lb, lh and friends dropped
                endcase
            end
            OP_STORE:
            begin
                case (funct3)
                    WORD:
                    begin
                        memWrite = 1'b1;
                        aluSrc   = 1'b1;   // address is rs1 + offset
                        immSrc   = IMM_S;
                    end
                    default: ;  // sb and sh dropped
                endcase
            end
            OP_BRANCH:
            begin
                case (funct3)
                    BEQ:
                    begin
                        isBeq   = 1'b1;
                        immSrc  = IMM_B;
                        aluCtrl = ALU_SUB;  // compare through zero flag
                    end
                    BNE:
                    begin
                        isBne   = 1'b1;
                        immSrc  = IMM_B;
                        aluCtrl = ALU_SUB;
                    end
                    default: ;  // blt, bge etc not decoded
                endcase
            end
            OP_JAL:
            begin
                isJal     = 1'b1;
                regWrite  = 1'b1;
                immSrc    = IMM_J;
                resultSrc = RES_PC4;  // link address
            end
            OP_LUI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = IMM_U;
                aluCtrl  = ALU_PASSB;  // immediate already shifted up
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

    // zero kept out of the decode block so the alu path has no loop
    assign pcSrc = isJal | (isBeq & zero) | (isBne & ~zero);

endmodule

/* source/execUnit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module execUnit
(
    input  logic                 clk,
    input  logic [31:0]          instr,      // current instruction word
    input  rvCtrlPkg::aluOpT     aluCtrl,    // alu operation
    input  logic                 aluSrc,     // operand b from immediate
    input  rvCtrlPkg::immSrcT    immSrc,     // immediate format
    input  logic                 rdWe,       // qualified rd write, x0 already filtered
    input  logic [`RV_XLEN-1:0]  rdData,     // write-back value
    output logic [`RV_XLEN-1:0]  aluResult,  // alu output, also memory address
    output logic [`RV_XLEN-1:0]  rs2Data,    // store data
    output logic [`RV_XLEN-1:0]  immExt,     // sign-extended immediate
    output logic                 zero        // aluResult == 0
);
    import rvCtrlPkg::*;

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];  // integer register file, no reset
    logic [4:0]          rs1Idx;            // instr[19:15]
    logic [4:0]          rs2Idx;            // instr[24:20]
    logic [4:0]          rdIdx;             // instr[11:7]
    logic [`RV_XLEN-1:0] rs1Data;           // operand a
    logic [`RV_XLEN-1:0] srcB;              // operand b after mux
    logic                lessThan;          // signed compare for slt

    assign rs1Idx = instr[19:15];
    assign rs2Idx = instr[24:20];
    assign rdIdx  = instr[11:7];

    // two async read ports, x0 reads zero
    assign rs1Data = (rs1Idx == 5'd0) ? '0 : regs[rs1Idx];
    assign rs2Data = (rs2Idx == 5'd0) ? '0 : regs[rs2Idx];

    // single write port, commit decides when
    always_ff @(posedge clk)
    begin
        if (rdWe)
        begin
            regs[rdIdx] <= rdData;
        end
    end

    // immediate generator
    always_comb
    begin
        case (immSrc)
            IMM_I:
            begin
                immExt = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_S:
            begin
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B:
            begin
                // offset in halfwords, lsb forced low
                immExt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            end
            IMM_U:
            begin
                immExt = {instr[31:12], 12'b0};  // low 12 bits cleared
            end
            IMM_J:
            begin
                immExt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            end
            default:
            begin
                immExt = '0;
            end
        endcase
    end

    // operand b select
    assign srcB     = aluSrc ? immExt : rs2Data;
    assign lessThan = $signed(rs1Data) < $signed(srcB);

    // alu
    always_comb
    begin
        case (aluCtrl)
            ALU_ADD:   aluResult = rs1Data + srcB;
            ALU_SUB:   aluResult = rs1Data - srcB;  // branches look at zero only
            ALU_AND:   aluResult = rs1Data & srcB;
            ALU_OR:    aluResult = rs1Data | srcB;
            ALU_XOR:   aluResult = rs1Data ^ srcB;
            ALU_SLT:   aluResult = {{(`RV_XLEN-1){1'b0}}, lessThan};
            ALU_PASSB: aluResult = srcB;            // lui
            default:   aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);  // feeds beq/bne decision

endmodule

/* source/commitUnit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module commitUnit
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrValid,    // one-cycle instruction strobe
    input  logic [31:0]            instr,         // for the rd field
    input  logic                   regWrite,      // decoder wants rd written
    input  logic                   memWrite,      // decoder wants a store
    input  rvCtrlPkg::resultSrcT   resultSrc,     // write-back select
    input  logic                   pcSrc,         // branch or jump taken
    input  logic [`RV_XLEN-1:0]    aluResult,     // alu output / address
    input  logic [`RV_XLEN-1:0]    rs2Data,       // store data
    input  logic [`RV_XLEN-1:0]    immExt,        // branch and jump offset
    output logic [`RV_XLEN-1:0]    pc,            // architectural pc
    output logic                   rdWe,          // register file write enable
    output logic [`RV_XLEN-1:0]    rdData,        // register file write data
    output logic                   retireValid,   // one cycle after the strobe
    output logic [`RV_XLEN-1:0]    retirePc,      // pc of retired instr
    output logic                   retireRdWe,    // it wrote a register
    output logic [4:0]             retireRd,      // destination index
    output logic [`RV_XLEN-1:0]    retireData,    // value written, valid with retireRdWe
    output logic [`RV_XLEN-1:0]    retireNextPc   // pc it handed on
);
    import rvCtrlPkg::*;

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);  // word index width

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];  // data memory, not cleared
    logic [DMEM_AW-1:0]  dmemIdx;                // word address
    logic [`RV_XLEN-1:0] memRdata;               // async read
    logic [`RV_XLEN-1:0] pcPlus4;                // sequential pc and link value
    logic [`RV_XLEN-1:0] nextPc;                 // pc after this instr
    logic [4:0]          rdIdx;                  // instr[11:7]

    assign rdIdx = instr[11:7];

    // word addressed, byte offset bits ignored
    assign dmemIdx  = aluResult[DMEM_AW+1:2];
    assign memRdata = dmem[dmemIdx];

    always_ff @(posedge clk)
    begin
        if (instrValid && memWrite)
        begin
            dmem[dmemIdx] <= rs2Data;  // sw only
        end
    end

    // write-back select
    always_comb
    begin
        case (resultSrc)
            RES_ALU: rdData = aluResult;
            RES_MEM: rdData = memRdata;
            RES_PC4: rdData = pcPlus4;  // jal link
            default: rdData = aluResult;
        endcase
    end

    // x0 is never written, the register file trusts this
    assign rdWe = instrValid & regWrite & (rdIdx != 5'd0);

    assign pcPlus4 = pc + `RV_XLEN'(4);
    assign nextPc  = pcSrc ? (pc + immExt) : pcPlus4;  // taken branch or jal

    // control state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc          <= `RV_RESET_PC;
            retireValid <= 1'b0;
            retireRdWe  <= 1'b0;
        end
        else
        begin
            retireValid <= instrValid;  // pulse one cycle after strobe
            retireRdWe  <= rdWe;        // already qualified by the strobe
            if (instrValid)
            begin
                pc <= nextPc;
            end
        end
    end

    // retire payload, held between instructions
    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            retirePc     <= pc;
            retireRd     <= rdIdx;
            retireData   <= rdData;
            retireNextPc <= nextPc;
        end
    end

endmodule

/* source/rvCore.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvCore
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,    // instruction strobe without back-pressure
    input  logic [31:0]          instr,         // word at address pc
    output logic [`RV_XLEN-1:0]  pc,            // fetch address for the driver
    output logic                 retireValid,   // retire report strobe
    output logic [`RV_XLEN-1:0]  retirePc,
    output logic                 retireRdWe,
    output logic [4:0]           retireRd,
    output logic [`RV_XLEN-1:0]  retireData,
    output logic [`RV_XLEN-1:0]  retireNextPc
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    opcodeT                opField;    // instr[6:0] as opcode
    aluOpT                 aluCtrl;    // decode to exec
    immSrcT                immSrc;
    resultSrcT             resultSrc;  // decode to commit
    logic                  aluSrc;
    logic                  regWrite;
    logic                  memWrite;
    logic                  pcSrc;
    logic                  zero;       // exec back to decode
    logic                  rdWe;       // commit back to exec
    logic [`RV_XLEN-1:0]   rdData;
    logic [`RV_XLEN-1:0]   aluResult;  // exec to commit
    logic [`RV_XLEN-1:0]   rs2Data;
    logic [`RV_XLEN-1:0]   immExt;

    assign opField = opcodeT'(instr[6:0]);

    controlUnit uControl
    (
        .op        (opField),
        .funct3    (instr[14:12]),
        .funct7    (instr[30]),
        .zero      (zero),
        .regWrite  (regWrite),
        .aluCtrl   (aluCtrl),
        .aluSrc    (aluSrc),
        .immSrc    (immSrc),
        .pcSrc     (pcSrc),
        .memWrite  (memWrite),
        .resultSrc (resultSrc)
    );

    execUnit uExec
    (
        .clk       (clk),
        .instr     (instr),
        .aluCtrl   (aluCtrl),
        .aluSrc    (aluSrc),
        .immSrc    (immSrc),
        .rdWe      (rdWe),
        .rdData    (rdData),
        .aluResult (aluResult),
        .rs2Data   (rs2Data),
        .immExt    (immExt),
        .zero      (zero)
    );

    commitUnit uCommit
    (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instr        (instr),
        .regWrite     (regWrite),
        .memWrite     (memWrite),
        .resultSrc    (resultSrc),
        .pcSrc        (pcSrc),
        .aluResult    (aluResult),
        .rs2Data      (rs2Data),
        .immExt       (immExt),
        .pc           (pc),
        .rdWe         (rdWe),
        .rdData       (rdData),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRdWe   (retireRdWe),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .retireNextPc (retireNextPc)
    );

endmodule

/* sim/rvCore_chk.sv */
`timescale 1ns/1ps

module rvCore_chk
(
    input logic        clk,
    input logic        rst,
    input logic        instrValid,
    input logic        retireValid,
    input logic        retireRdWe,
    input logic [4:0]  retireRd,
    input logic [31:0] retireNextPc
);

    // every strobe gives a report one cycle later
    strobeToRetire: assert property (@(posedge clk) disable iff (rst)
        instrValid |=> retireValid)
        else $error("retireValid missing one cycle after instrValid");

    // and no report without a strobe
    noSpuriousRetire: assert property (@(posedge clk) disable iff (rst)
        !instrValid |=> !retireValid)
        else $error("retireValid high without a preceding instrValid");

    // quiet through reset and the cycle after
    resetQuiet: assert property (@(posedge clk) rst |=> !retireValid)
        else $error("retireValid high during or right after reset");

    rdNonZero: assert property (@(posedge clk) disable iff (rst)
        retireRdWe |-> retireRd != 5'd0)
        else $error("retireRdWe reported for x0");

    alignedNextPc: assert property (@(posedge clk) disable iff (rst)
        retireValid |-> retireNextPc[1:0] == 2'b00)
        else $error("retireNextPc not word aligned");

endmodule

bind rvCore rvCore_chk uChk
(
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .retireValid  (retireValid),
    .retireRdWe   (retireRdWe),
    .retireRd     (retireRd),
    .retireNextPc (retireNextPc)
);

/* sim/rvCore_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvCore_tb;
    import rvIsaPkg::*;

    localparam int CLK_PERIOD = 20;

    typedef struct packed
    {
        logic [31:0] instr;   // instruction word
        logic [31:0] addr;    // pc it sits at
        logic        rdWe;    // expected register write
        logic [4:0]  rd;
        logic [31:0] data;    // only checked with rdWe
        logic [31:0] nextPc;
    } rowT;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retireValid;
    logic [31:0] retirePc;
    logic        retireRdWe;
    logic [4:0]  retireRd;
    logic [31:0] retireData;
    logic [31:0] retireNextPc;

    rowT prog[$];          // straight-line trace
    bit  progLoaded = 0;
    int  errors     = 0;   // total mismatches
    int  passed     = 0;
    int  failed     = 0;

    rvCore u_dut
    (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instr        (instr),
        .pc           (pc),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRdWe   (retireRdWe),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .retireNextPc (retireNextPc)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // assemblers take fields in rd, rs1, rs2, imm order
    function automatic logic [31:0] encR(int f7, int rd, logic [2:0] f3, int rs1, int rs2);
        encR = {1'b0, f7[0], 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] encI(int rd, logic [2:0] f3, int rs1, int imm,
                                         logic [6:0] op);
        encI = {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(logic [2:0] f3, int rs1, int rs2, int imm);
        encS = {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [2:0] f3, int rs1, int rs2, int imm);
        encB = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(int rd, int imm);
        encJ = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic logic [31:0] encU(int rd, int imm20);
        encU = {imm20[19:0], rd[4:0], OP_LUI};
    endfunction

    task automatic addRow(input logic [31:0] ins, input int addr, input int we, input int rd,
                          input logic [31:0] data, input int npc);
        rowT r;
        r.instr  = ins;
        r.addr   = addr;
        r.rdWe   = (we != 0);
        r.rd     = rd[4:0];
        r.data   = data;
        r.nextPc = npc;
        prog.push_back(r);
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED t=%0t %s: got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic loadProgram();
        addRow(encI(1, ADD_SUB, 0, -5, OP_IMM), 0, 1, 1, 32'hFFFF_FFFB, 4);  // x1 = -5
        addRow(encI(2, ADD_SUB, 0, 60, OP_IMM), 4, 1, 2, 32'h0000_003C, 8);  // x2 = 60
        addRow(encI(3, AND, 2, 15, OP_IMM), 8, 1, 3, 32'h0000_000C, 12);
        addRow(encI(4, OR, 2, 257, OP_IMM), 12, 1, 4, 32'h0000_013D, 16);
        addRow(encI(5, XOR, 1, 255, OP_IMM), 16, 1, 5, 32'hFFFF_FF04, 20);
        addRow(encI(6, SLT, 1, 1, OP_IMM), 20, 1, 6, 32'h1, 24);            // -5 < 1
        addRow(encR(0, 7, ADD_SUB, 1, 2), 24, 1, 7, 32'h37, 28);
        addRow(encR(1, 8, ADD_SUB, 2, 1), 28, 1, 8, 32'h41, 32);             // 60 - -5
        addRow(encR(0, 9, AND, 1, 2), 32, 1, 9, 32'h38, 36);
        addRow(encR(0, 10, OR, 1, 2), 36, 1, 10, 32'hFFFF_FFFF, 40);
        addRow(encR(0, 11, XOR, 1, 2), 40, 1, 11, 32'hFFFF_FFC7, 44);
        addRow(encR(0, 12, SLT, 2, 1), 44, 1, 12, 32'h0, 48);                // 60 < -5 false
        addRow(encU(13, 'h12345), 48, 1, 13, 32'h1234_5000, 52);
        addRow(encS(WORD, 2, 7, 8), 52, 0, 0, 0, 56);                        // mem[68] = 55
        addRow(encI(14, WORD, 2, 8, OP_LOAD), 56, 1, 14, 32'h37, 60);
        addRow(encB(BEQ, 7, 14, 12), 60, 0, 0, 0, 72);                       // taken
        addRow(encB(BEQ, 1, 2, 100), 72, 0, 0, 0, 76);                      // not taken
        addRow(encB(BNE, 1, 2, 12), 76, 0, 0, 0, 88);                        // taken
        addRow(encB(BNE, 7, 14, -24), 88, 0, 0, 0, 92);                      // not taken
        addRow(encJ(15, 16), 92, 1, 15, 32'h60, 108);                        // link 96
        addRow(encI(0, ADD_SUB, 1, 7, OP_IMM), 108, 0, 0, 0, 112);           // x0 stays 0
        addRow(encR(0, 16, ADD_SUB, 0, 2), 112, 1, 16, 32'h3C, 116);         // reads x0
        addRow(encI(5, 3'b000, 0, 0, 7'b0001111), 116, 0, 0, 0, 120);        // unknown opcode
        addRow(encR(0, 17, 3'b001, 1, 2), 120, 0, 0, 0, 124);                // sll not decoded
        addRow(encJ(0, -124), 124, 0, 0, 0, 0);                              // back to 0 without link
    endtask

    // watchdog sized from the table
    initial
    begin
        wait (progLoaded);
        #((prog.size() * 4 + 40) * CLK_PERIOD);
        $display("timeout: run did not finish by %0t", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        rowT row;
        int  errBefore;
        int  gap;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        void'($urandom(21360));
        loadProgram();
        progLoaded = 1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq("pc after reset", pc, `RV_RESET_PC);
        checkEq("retireValid after reset", 32'(retireValid), 0);
        @(posedge clk);
        instr      <= prog[0].instr;
        instrValid <= 1'b1;
        for (int i = 0; i < prog.size(); i++)
        begin
            row       = prog[i];
            errBefore = errors;
            gap       = $urandom_range(2);  // idle cycles before the next row
            @(posedge clk);                 // row i sampled here
            if (gap == 0 && i + 1 < prog.size())
            begin
                instr <= prog[i + 1].instr;  // back-to-back strobe
            end
            else
            begin
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (!retireValid)
            begin
                $display("row %0d: no retire report after the strobe", i);
                errors++;
            end
            else
            begin
                checkEq("retirePc", retirePc, row.addr);
                checkEq("retireRdWe", 32'(retireRdWe), 32'(row.rdWe));
                if (row.rdWe)
                begin
                    checkEq("retireRd", 32'(retireRd), 32'(row.rd));
                    checkEq("retireData", retireData, row.data);
                end
                checkEq("retireNextPc", retireNextPc, row.nextPc);
                checkEq("pc", pc, row.nextPc);  // new pc visible with the report
            end
            if (errors == errBefore)
            begin
                passed++;
                $display("row %0d pc %h: pass", i, row.addr);
            end
            else
            begin
                failed++;
                $display("row %0d pc %h: fail", i, row.addr);
            end
            if (gap != 0 && i + 1 < prog.size())
            begin
                repeat (gap) @(posedge clk);  // idle gap
                instr      <= prog[i + 1].instr;
                instrValid <= 1'b1;
            end
        end
        @(negedge clk);
        $display("summary: %0d rows passed, %0d rows failed, %0d mismatches",
                 passed, failed, errors);
        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* rvCore.f */
+incdir+source
source/rvIsaPkg.sv
source/rvCtrlPkg.sv
source/controlUnit.sv
source/execUnit.sv
source/commitUnit.sv
source/rvCore.sv
sim/rvCore_chk.sv
sim/rvCore_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rvCore_tb
FILELIST = rvCore.f
OBJDIR   = obj_dir

.PHONY: sim clean

# build, run, and pass only when the pass line shows up in stdout
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf $(OBJDIR)
